// File: src/wfd_pkg.sv
// readout path definitions shared by the master FPGA trigger and event building logic
package wfd_pkg;

    //////////////////////////////////////////////////////////////////////
    // channel side
    //////////////////////////////////////////////////////////////////////
    localparam int NUM_CHAN    = 5;                  // channel FPGAs on the board
    localparam int CHAN_WORD_W = 32;                 // one word of a channel frame
    localparam int CHAN_IDX_W  = 3;                  // enough to count 0..4

    typedef logic [NUM_CHAN-1:0]    chan_mask_t;     // go, done, valid, last, ready
    typedef logic [CHAN_WORD_W-1:0] chan_word_t;
    typedef logic [CHAN_IDX_W-1:0]  chan_idx_t;

    localparam chan_idx_t LAST_CHAN = chan_idx_t'(NUM_CHAN - 1);

    //////////////////////////////////////////////////////////////////////
    // trigger numbers and DAQ words
    //////////////////////////////////////////////////////////////////////
    localparam int TRIG_NUM_W = 24;                  // same width as the AMC13 event number
    localparam int DAQ_WORD_W = 64;
    localparam int WORD_CNT_W = 24;                  // payload words per event, in the trailer

    typedef logic [TRIG_NUM_W-1:0] trig_num_t;
    typedef logic [DAQ_WORD_W-1:0] daq_word_t;
    typedef logic [WORD_CNT_W-1:0] word_cnt_t;

    localparam logic [7:0] HEADER_TAG = 8'hA5;       // top byte of every header word

    //////////////////////////////////////////////////////////////////////
    // trigger number FIFO
    //////////////////////////////////////////////////////////////////////
    localparam int TRIG_FIFO_DEPTH = 4;
    localparam int TRIG_FIFO_PTR_W = $clog2(TRIG_FIFO_DEPTH);
    localparam int TRIG_FIFO_CNT_W = $clog2(TRIG_FIFO_DEPTH + 1);  // must hold the full count

    typedef logic [TRIG_FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [TRIG_FIFO_CNT_W-1:0] fifo_cnt_t;

    // state machines
    typedef enum logic [1:0] {
        EB_IDLE,        // waiting for a trigger number
        EB_HEADER,      // pop the number and load the header
        EB_PAYLOAD,     // forward channel words, channel 0 first
        EB_TRAILER      // load the trailer with the word count
    } eb_state_t;

    typedef enum logic [1:0] {
        TM_IDLE,        // ready for a trigger
        TM_GO,          // go high, waiting for all dones
        TM_RELEASE,     // go low, waiting for dones to clear
        TM_PUSH         // trigger number offered to the FIFO
    } tm_state_t;

endpackage

// File: src/trigger_manager.sv
// trigger manager: go/done handshake with the channel FPGAs and trigger numbering
module trigger_manager import wfd_pkg::*; (
    input  logic       clk125,
    input  logic       arst_n,

    // trigger input and status
    input  logic       trigger,      // sampled on every edge, ignored while busy
    output logic       busy,         // high from acceptance until the number is queued

    // four-phase handshake with the channels
    output chan_mask_t acq_trigs,    // go, one bit per channel, all bits move together
    input  chan_mask_t acq_dones,    // done, answered per channel

    // trigger number stream towards the FIFO
    output logic       num_valid,
    input  logic       num_ready,
    output trig_num_t  num           // running count, first trigger is 1
);

    tm_state_t state;

    logic all_done;     // every channel has finished
    logic none_done;    // every channel has dropped its done
    logic accept;       // trigger taken this edge
    logic pushed;       // number handed to the FIFO this edge

    assign all_done  = &acq_dones;
    assign none_done = ~|acq_dones;
    assign accept    = (state == TM_IDLE) && trigger && !busy;
    assign pushed    = num_valid && num_ready;

    //////////////////////////////////////////////////////////////////////
    // handshake FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state     <= TM_IDLE;
            busy      <= 1'b0;
            acq_trigs <= '0;
            num_valid <= 1'b0;
            num       <= '0;            // first increment gives 1
        end else begin
            case (state)
                TM_IDLE: begin
                    if (accept) begin
                        busy      <= 1'b1;
                        acq_trigs <= '1;            // go to all channels at once
                        num       <= num + 1'b1;    // number the trigger now
                        state     <= TM_GO;
                    end
                end

                TM_GO: begin
                    // hold go until the slowest channel reports done
                    if (all_done) begin
                        acq_trigs <= '0;
                        state     <= TM_RELEASE;
                    end
                end

                TM_RELEASE: begin
                    if (none_done) begin
                        num_valid <= 1'b1;          // num already holds this trigger
                        state     <= TM_PUSH;
                    end
                end

                TM_PUSH: begin
                    // FIFO full stalls here, busy stays up and new triggers are dropped
                    if (pushed) begin
                        num_valid <= 1'b0;
                        busy      <= 1'b0;
                        state     <= TM_IDLE;
                    end
                end

                default: begin
                    state <= TM_IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/trig_num_fifo.sv
// trigger number FIFO between the trigger manager and the event builder
module trig_num_fifo import wfd_pkg::*; (
    input  logic      clk125,
    input  logic      arst_n,

    // write side, from the trigger manager
    input  logic      in_valid,
    output logic      in_ready,     // low when all entries are taken
    input  trig_num_t in_num,

    // read side, to the event builder
    output logic      out_valid,
    input  logic      out_ready,
    output trig_num_t out_num
);

    trig_num_t mem [TRIG_FIFO_DEPTH];   // storage, no reset needed

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;                   // entries held

    logic push;
    logic pop;

    // step a pointer around the ring
    function automatic fifo_ptr_t ptr_inc(input fifo_ptr_t ptr);
        if (ptr == fifo_ptr_t'(TRIG_FIFO_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != fifo_cnt_t'(TRIG_FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_num   = mem[rd_ptr];     // head entry, shows up the cycle after the push
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk125) begin
        if (push)
            mem[wr_ptr] <= in_num;
    end

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            // push and pop together leave the count alone
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

// File: src/event_builder.sv
// event builder: header, channel 0..4 frames and trailer per trigger number onto the DAQ port
module event_builder import wfd_pkg::*; (
    input  logic                      clk125,
    input  logic                      arst_n,

    // trigger numbers from the FIFO
    input  logic                      num_valid,
    output logic                      num_ready,
    input  trig_num_t                 num,

    // channel frames
    input  chan_mask_t                chan_valid,
    input  chan_mask_t                chan_last,
    input  chan_word_t [NUM_CHAN-1:0] chan_data,
    output chan_mask_t                chan_ready,   // one-hot or zero

    // DAQ link
    output logic                      daq_valid,
    output logic                      daq_header,
    output logic                      daq_trailer,
    output daq_word_t                 daq_data,
    input  logic                      daq_ready
);

    eb_state_t state;
    chan_idx_t chan_idx;        // channel being read out
    trig_num_t trig_num_q;      // number of the event in progress
    word_cnt_t word_cnt;        // payload words sent so far

    logic       out_free;       // output register can take a word this edge
    logic       pop;
    logic       sel_valid;      // selected channel, the old rx switch reduced to a mux
    logic       sel_last;
    chan_word_t sel_data;
    logic       chan_xfer;      // channel word accepted this edge

    logic       out_load;
    logic       out_hdr;
    logic       out_trl;
    daq_word_t  out_word;

    assign out_free  = !daq_valid || daq_ready;
    assign pop       = num_valid && num_ready;
    assign sel_valid = chan_valid[chan_idx];
    assign sel_last  = chan_last[chan_idx];
    assign sel_data  = chan_data[chan_idx];
    assign chan_xfer = sel_valid && chan_ready[chan_idx];

    // pop only when the header can be loaded right away
    assign num_ready = (state == EB_HEADER) && out_free;

    always_comb begin
        chan_ready = '0;
        if (state == EB_PAYLOAD && out_free)
            chan_ready[chan_idx] = 1'b1;    // follows daq_ready while a word is held
    end

    //////////////////////////////////////////////////////////////////////
    // next DAQ word
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        out_load = 1'b0;
        out_hdr  = 1'b0;
        out_trl  = 1'b0;
        out_word = '0;
        case (state)
            EB_HEADER: begin
                out_load                          = pop;
                out_hdr                           = 1'b1;
                out_word[DAQ_WORD_W-1 -: 8]       = HEADER_TAG;
                out_word[TRIG_NUM_W-1:0]          = num;
            end
            EB_PAYLOAD: begin
                out_load                          = chan_xfer;
                out_word[CHAN_WORD_W +: CHAN_IDX_W] = chan_idx;   // bits 34:32
                out_word[CHAN_WORD_W-1:0]         = sel_data;
            end
            EB_TRAILER: begin
                out_load                          = out_free;
                out_trl                           = 1'b1;
                out_word[32 +: WORD_CNT_W]        = word_cnt;     // bits 55:32
                out_word[TRIG_NUM_W-1:0]          = trig_num_q;
            end
            default: ;
        endcase
    end

    // output register, data side
    always_ff @(posedge clk125) begin
        if (out_load)
            daq_data <= out_word;           // held while daq_ready is low
    end

    // output register, flags
    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
        end else if (out_load) begin
            daq_valid   <= 1'b1;
            daq_header  <= out_hdr;
            daq_trailer <= out_trl;
        end else if (daq_ready) begin
            daq_valid   <= 1'b0;            // word gone, nothing new
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // event FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state      <= EB_IDLE;
            chan_idx   <= '0;
            trig_num_q <= '0;
            word_cnt   <= '0;
        end else begin
            case (state)
                EB_IDLE: begin
                    if (num_valid) begin
                        chan_idx <= '0;
                        word_cnt <= '0;
                        state    <= EB_HEADER;
                    end
                end

                EB_HEADER: begin
                    if (pop) begin
                        trig_num_q <= num;      // kept for the trailer
                        state      <= EB_PAYLOAD;
                    end
                end

                EB_PAYLOAD: begin
                    if (chan_xfer) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (sel_last) begin
                            if (chan_idx == LAST_CHAN)
                                state <= EB_TRAILER;
                            else
                                chan_idx <= chan_idx + 1'b1;
                        end
                    end
                end

                EB_TRAILER: begin
                    if (out_free)
                        state <= EB_IDLE;       // trailer may still be waiting on daq_ready
                end

                default: begin
                    state <= EB_IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/wfd_top.sv
// master FPGA readout top: trigger manager, trigger number FIFO and event builder
module wfd_top import wfd_pkg::*; (
    input  logic                      clk125,       // system clock
    input  logic                      arst_n,

    // trigger and channel handshake
    input  logic                      trigger,
    output logic                      busy,
    output chan_mask_t                acq_trigs,    // go to channel FPGAs
    input  chan_mask_t                acq_dones,    // done from channel FPGAs

    // channel frames
    input  chan_mask_t                chan_valid,
    input  chan_mask_t                chan_last,
    input  chan_word_t [NUM_CHAN-1:0] chan_data,
    output chan_mask_t                chan_ready,

    // DAQ link
    output logic                      daq_valid,
    output logic                      daq_header,
    output logic                      daq_trailer,
    output daq_word_t                 daq_data,
    input  logic                      daq_ready
);

    // trigger manager to FIFO
    logic      tm_num_valid;
    logic      tm_num_ready;
    trig_num_t tm_num;

    // FIFO to event builder
    logic      eb_num_valid;
    logic      eb_num_ready;
    trig_num_t eb_num;

    //////////////////////////////////////////////////////////////////////
    // acquisition side
    //////////////////////////////////////////////////////////////////////
    trigger_manager u_tm (
        .clk125    (clk125),
        .arst_n    (arst_n),
        .trigger   (trigger),
        .busy      (busy),
        .acq_trigs (acq_trigs),
        .acq_dones (acq_dones),
        .num_valid (tm_num_valid),
        .num_ready (tm_num_ready),
        .num       (tm_num)
    );

    // decouples acquisition from readout
    trig_num_fifo u_fifo (
        .clk125    (clk125),
        .arst_n    (arst_n),
        .in_valid  (tm_num_valid),
        .in_ready  (tm_num_ready),
        .in_num    (tm_num),
        .out_valid (eb_num_valid),
        .out_ready (eb_num_ready),
        .out_num   (eb_num)
    );

    //////////////////////////////////////////////////////////////////////
    // readout side
    //////////////////////////////////////////////////////////////////////
    event_builder u_eb (
        .clk125      (clk125),
        .arst_n      (arst_n),
        .num_valid   (eb_num_valid),
        .num_ready   (eb_num_ready),
        .num         (eb_num),
        .chan_valid  (chan_valid),
        .chan_last   (chan_last),
        .chan_data   (chan_data),
        .chan_ready  (chan_ready),
        .daq_valid   (daq_valid),
        .daq_header  (daq_header),
        .daq_trailer (daq_trailer),
        .daq_data    (daq_data),
        .daq_ready   (daq_ready)
    );

endmodule

// File: tb/wfd_sva.sv
// protocol assertions for the readout top, go/done handshake, DAQ port and channel select
module wfd_sva import wfd_pkg::*; (
    input logic       clk125,
    input logic       arst_n,
    input chan_mask_t acq_trigs,
    input chan_mask_t acq_dones,
    input chan_mask_t chan_ready,
    input logic       daq_valid,
    input logic       daq_header,
    input logic       daq_trailer,
    input daq_word_t  daq_data,
    input logic       daq_ready
);

    int unsigned fails = 0;     // failed assertions so far, watched by the testbench

    // go stays up until the slowest channel is done
    go_held: assert property (@(posedge clk125) disable iff (!arst_n)
        (acq_trigs != '0) && !(&acq_dones) |=> (acq_trigs == $past(acq_trigs)))
        else begin
            fails++;
            $error("acq_trigs changed before every channel was done");
        end

    // a stalled DAQ word keeps its data and flags
    daq_stable: assert property (@(posedge clk125) disable iff (!arst_n)
        daq_valid && !daq_ready |=>
            daq_valid && $stable(daq_data) && $stable(daq_header) && $stable(daq_trailer))
        else begin
            fails++;
            $error("DAQ word changed while stalled");
        end

    hdr_trl_excl: assert property (@(posedge clk125) disable iff (!arst_n)
        !(daq_header && daq_trailer))
        else begin
            fails++;
            $error("header and trailer flags high together");
        end

    flags_need_valid: assert property (@(posedge clk125) disable iff (!arst_n)
        (daq_header || daq_trailer) |-> daq_valid)
        else begin
            fails++;
            $error("header or trailer flag without daq_valid");
        end

    // the receive mux selects one channel at most
    ready_onehot: assert property (@(posedge clk125) disable iff (!arst_n)
        $onehot0(chan_ready))
        else begin
            fails++;
            $error("more than one chan_ready bit high");
        end

endmodule

bind wfd_top wfd_sva u_sva (
    .clk125      (clk125),
    .arst_n      (arst_n),
    .acq_trigs   (acq_trigs),
    .acq_dones   (acq_dones),
    .chan_ready  (chan_ready),
    .daq_valid   (daq_valid),
    .daq_header  (daq_header),
    .daq_trailer (daq_trailer),
    .daq_data    (daq_data),
    .daq_ready   (daq_ready)
);

// File: tb/tb_wfd_top.sv
// testbench for the readout top with channel models, random triggers and a DAQ reference model
module tb_wfd_top import wfd_pkg::*; ();

    localparam int N_EVENTS  = 40;              // accepted triggers per run
    localparam int MAX_WORDS = 4;               // longest channel frame
    localparam int MAX_DLY   = 7;               // done rise and fall delay, a power of two minus 1
    localparam int MAX_LOW   = 143;             // longest daq_ready low stretch
    localparam int EVENT_CYC = (2 + NUM_CHAN * MAX_WORDS) * (MAX_LOW + 8) + 4 * MAX_DLY + 64;
    localparam int TIMEOUT   = (N_EVENTS * EVENT_CYC + 200) * 10;

    logic                      clk125;
    logic                      arst_n;
    logic                      trigger;
    logic                      busy;
    chan_mask_t                acq_trigs;
    chan_mask_t                acq_dones;
    chan_mask_t                chan_valid;
    chan_mask_t                chan_last;
    chan_word_t [NUM_CHAN-1:0] chan_data;
    chan_mask_t                chan_ready;
    logic                      daq_valid;
    logic                      daq_header;
    logic                      daq_trailer;
    daq_word_t                 daq_data;
    logic                      daq_ready;

    integer seed = 32'h2aeb4a7f;

    // channel side, one queue pair per channel
    chan_word_t  drv_w    [NUM_CHAN][$];    // words not yet taken by the DUT
    logic        drv_last [NUM_CHAN][$];
    chan_word_t  mdl_w    [NUM_CHAN][$];    // same words, for the model
    int          mdl_len  [NUM_CHAN][$];    // frame lengths, oldest first
    int          dly      [NUM_CHAN];       // cycles left before the done bit moves

    // reference model
    trig_num_t   acc_q[$];                  // numbers of accepted triggers
    logic [65:0] exp_q[$];                  // {header, trailer, data} expected on the DAQ port
    trig_num_t   next_num;
    int          n_acc;
    int          n_trl;                     // trailers seen = events read out

    int          rdy_left;                  // cycles left in the daq_ready phase
    logic        run;
    chan_mask_t  go_q;                      // acq_trigs at the last falling edge

    // taken at the rising edge, used at the next falling edge
    chan_mask_t  chan_take;
    logic        daq_take;
    logic [65:0] daq_seen;
    logic        trig_acc;

    wfd_top u_wfd_top (
        .clk125      (clk125),
        .arst_n      (arst_n),
        .trigger     (trigger),
        .busy        (busy),
        .acq_trigs   (acq_trigs),
        .acq_dones   (acq_dones),
        .chan_valid  (chan_valid),
        .chan_last   (chan_last),
        .chan_data   (chan_data),
        .chan_ready  (chan_ready),
        .daq_valid   (daq_valid),
        .daq_header  (daq_header),
        .daq_trailer (daq_trailer),
        .daq_data    (daq_data),
        .daq_ready   (daq_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check(input string name, input logic [65:0] exp, input logic [65:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("** Error: %s", why);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    // one frame of 1..MAX_WORDS random words for channel c
    task automatic add_frame(input int c);
        int         len;
        chan_word_t w;
        len = 1 + ($random(seed) & (MAX_WORDS - 1));
        mdl_len[c].push_back(len);
        for (int k = 0; k < len; k++) begin
            w = chan_word_t'($random(seed));
            drv_w[c].push_back(w);
            drv_last[c].push_back(k == len - 1);
            mdl_w[c].push_back(w);
        end
    endtask

    function automatic logic frames_complete();
        for (int c = 0; c < NUM_CHAN; c++)
            if (mdl_len[c].size() == 0)
                return 1'b0;
        return 1'b1;
    endfunction

    // every channel has a frame for the oldest trigger, so its event is known
    task automatic build_events();
        trig_num_t num;
        word_cnt_t cnt;
        chan_idx_t idx;
        int        len;
        while (frames_complete()) begin
            if (acc_q.size() == 0) begin
                abort_run("channel frames arrived for a trigger that was never accepted");
            end else begin
                num = acc_q.pop_front();
                cnt = '0;
                exp_q.push_back({2'b10, HEADER_TAG, 32'h0, num});
                for (int c = 0; c < NUM_CHAN; c++) begin
                    len = mdl_len[c].pop_front();
                    idx = chan_idx_t'(c);
                    for (int k = 0; k < len; k++) begin
                        exp_q.push_back({2'b00, 29'h0, idx, mdl_w[c].pop_front()});
                        cnt = word_cnt_t'(cnt + 1);
                    end
                end
                exp_q.push_back({2'b01, 8'h00, cnt, 8'h00, num});    // trailer
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, reset, end of run
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk125 = 1'b0;
        forever #5 clk125 = ~clk125;
    end

    initial begin
        arst_n     = 1'b0;
        trigger    = 1'b0;
        acq_dones  = '0;
        chan_valid = '0;
        chan_last  = '0;
        chan_data  = '0;
        daq_ready  = 1'b0;
        run        = 1'b0;
        next_num   = trig_num_t'(1);        // first accepted trigger is number 1
        n_acc      = 0;
        n_trl      = 0;
        rdy_left   = 0;
        go_q       = '0;
        chan_take  = '0;
        daq_take   = 1'b0;
        daq_seen   = '0;
        trig_acc   = 1'b0;
        for (int c = 0; c < NUM_CHAN; c++)
            dly[c] = 0;
        repeat (8) @(posedge clk125);
        @(negedge clk125);
        arst_n = 1'b1;
        repeat (10) @(posedge clk125);      // idle outputs checked here
        run = 1'b1;
        wait (n_trl == N_EVENTS);
        repeat (200) @(posedge clk125);     // room for any stray word to show up
        if (exp_q.size() == 0 && n_acc == N_EVENTS) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("** Error: %0d expected DAQ words never arrived", exp_q.size());
            $display("Verification failed");
            $fatal(1, "run stopped");
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("** Error: watchdog expired after %0d of %0d events", n_trl, N_EVENTS);
        $display("Verification failed");
        $fatal(1, "run stopped on timeout");
    end

    always @(posedge clk125) begin
        chan_take <= chan_valid & chan_ready;
        daq_take  <= daq_valid & daq_ready;
        daq_seen  <= {daq_header, daq_trailer, daq_data};
        trig_acc  <= arst_n & trigger & ~busy;      // acceptance rule
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus, channel models and checks on the falling edge
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk125) begin
        if (u_wfd_top.u_sva.fails != 0)
            abort_run("a protocol assertion on the DUT ports failed");
        if (arst_n && !run)
            check("reset_idle", '0, {acq_trigs, busy, chan_ready, daq_valid});
        if (run) begin
            if (trig_acc) begin
                check("go_after_accept", chan_mask_t'('1), acq_trigs);
                check("busy_after_accept", 1'b1, busy);
                acc_q.push_back(next_num);
                next_num = trig_num_t'(next_num + 1);
                n_acc++;
            end

            // four-phase handshake seen from the channels
            if (acq_trigs != go_q) begin
                if (acq_trigs != '0)
                    check("go_rise_dones_low", '0, acq_dones);
                else
                    check("go_fall_dones_high", chan_mask_t'('1), acq_dones);
            end
            check("go_all_bits", 1'b1, (acq_trigs == '0) || (acq_trigs == '1));
            go_q = acq_trigs;

            // done follows go after a random delay, a frame follows the release
            for (int c = 0; c < NUM_CHAN; c++) begin
                if (acq_trigs[c] != acq_dones[c]) begin
                    if (dly[c] > 0) begin
                        dly[c]--;
                    end else begin
                        acq_dones[c] = acq_trigs[c];
                        dly[c]       = $random(seed) & MAX_DLY;
                        if (!acq_trigs[c])
                            add_frame(c);
                    end
                end
            end
            build_events();

            // frame words, held until taken, random gaps otherwise
            for (int c = 0; c < NUM_CHAN; c++) begin
                if (chan_take[c]) begin
                    drv_w[c].delete(0);
                    drv_last[c].delete(0);
                    chan_valid[c] = 1'b0;
                end
                if (!chan_valid[c] && drv_w[c].size() > 0 && ($random(seed) & 3) != 0) begin
                    chan_valid[c] = 1'b1;
                    chan_data[c]  = drv_w[c][0];
                    chan_last[c]  = drv_last[c][0];
                end
            end

            // DAQ back-pressure, long lows let the trigger FIFO fill
            if (rdy_left == 0) begin
                if (($random(seed) & 3) == 0) begin
                    daq_ready = 1'b0;
                    rdy_left  = 16 + ($random(seed) & 127);
                end else begin
                    daq_ready = 1'b1;
                    rdy_left  = 1 + ($random(seed) & 15);
                end
            end else begin
                rdy_left--;
            end

            if (daq_take) begin
                if (exp_q.size() == 0) begin
                    abort_run("a DAQ word arrived while no event was expected");
                end else begin
                    check($sformatf("daq_word event %0d", n_trl + 1), exp_q.pop_front(), daq_seen);
                    if (daq_seen[64])
                        n_trl++;
                end
            end

            // random triggers, busy or not, until enough were accepted
            trigger = (n_acc < N_EVENTS) && (($random(seed) & 3) == 0);
        end
    end

endmodule

// File: wfd.f
src/wfd_pkg.sv
src/trigger_manager.sv
src/trig_num_fifo.sv
src/event_builder.sv
src/wfd_top.sv
tb/wfd_sva.sv
tb/tb_wfd_top.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_wfd_top
FILELIST   = wfd.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -j 0
RUN_FLAGS  = +verilator+error+limit+100
PASS_MSG   = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
